//--- fpa_params.svh
// fixed widths of the word bus and the mantissa
// FIFO depth here is only the default, the FIFO parameter may override it
`ifndef FPA_PARAMS_SVH
`define FPA_PARAMS_SVH

// bus word width
`define FPA_WORD_W 16

// mantissa width, bit 0 is the msb
`define FPA_MANT_W 40

// default command FIFO depth
`define FPA_FIFO_DEPTH 4

// largest shift count
// bigger counts in a control word are clamped to this
`define FPA_MAX_SHIFT 40

`endif

//--- fpa_bus_pkg.sv
// word-bus types for the assembler, the command FIFO and the unit
// bit 15 is the msb of a bus word, operand bits run 0 (msb) to 39
`include "fpa_params.svh"

package fpa_bus_pkg;

	// 3-bit opcode
	// codes 6 and 7 do nothing
	typedef enum logic [2:0] {
		OP_LOAD = 3'd0,
		OP_ADD  = 3'd1,
		OP_SUB  = 3'd2,
		OP_SHR  = 3'd3,
		OP_SHL  = 3'd4,
		OP_READ = 3'd5,
		OP_NOP6 = 3'd6,
		OP_NOP7 = 3'd7
	} fpa_op_e;

	// first word of a command
	typedef struct packed {
		fpa_op_e op;
		logic [5:0] count;
		logic [6:0] rsvd;
	} fpa_ctrl_t;

	// one bus word, control view or plain data view
	typedef union packed {
		fpa_ctrl_t ctrl;
		logic [`FPA_WORD_W-1:0] data;
	} fpa_word_u;

	// assembled command as stored in the FIFO
	// operand is word1, word2, then the upper byte of word3
	typedef struct packed {
		fpa_op_e op;
		logic [5:0] count;
		logic [0:`FPA_MANT_W-1] operand;
	} fpa_cmd_t;

endpackage

//--- fpa_data_pkg.sv
// datapath types of the arithmetic unit
// mantissa bit 0 is the sign
`include "fpa_params.svh"

package fpa_data_pkg;

	// 40-bit mantissa, 0 is the msb
	typedef logic [0:`FPA_MANT_W-1] fpa_mant_t;

	// flag word bits, in the order they leave on the bus
	typedef struct packed {
		// T is zero
		logic z;
		// sign of T
		logic m;
		// signed overflow of last add or subtract
		logic v;
		// carry above bit 0, no borrow on subtract
		logic c;
	} fpa_flags_t;

	// adder carries between the three segments
	typedef struct packed {
		// above bit 0
		logic fp0;
		// above bit 16
		logic fp16;
		// above bit 32
		logic p32;
	} fpa_carry_t;

endpackage

//--- fpa_word_assembler.sv
// builds commands from 16-bit words on a four-phase req/ack link
// the source must keep in_word stable while in_req is high
`include "fpa_params.svh"

module fpa_word_assembler (
	input  logic                   clk_sys,
	input  logic                   _0_t,
	input  logic                   in_req,
	input  fpa_bus_pkg::fpa_word_u in_word,
	output logic                   in_ack,
	input  logic                   full,
	output logic                   push,
	output fpa_bus_pkg::fpa_cmd_t  cmd
);

	// operand words still to come
	// 0 means the next word is a control word
	logic [1:0] words_left;
	logic first;
	logic has_opnd;
	logic is_final;
	logic take;

	assign first = (words_left == 2'd0);

	// LOAD, ADD and SUB carry three operand words
	assign has_opnd = in_word.ctrl.op inside {fpa_bus_pkg::OP_LOAD,
		fpa_bus_pkg::OP_ADD, fpa_bus_pkg::OP_SUB};

	// last word of a command completes it
	assign is_final = first ? !has_opnd : (words_left == 2'd1);

	// new word seen
	// a final word waits while the FIFO is full
	assign take = in_req && !in_ack && !(is_final && full);

	// handshake phase and word position
	always_ff @(posedge clk_sys or posedge _0_t) begin
		if (_0_t) begin
			in_ack <= 1'b0;
			push <= 1'b0;
			words_left <= 2'd0;
		end else begin
			push <= 1'b0;
			if (take) begin
				in_ack <= 1'b1;
				// push goes out with the final ack
				push <= is_final;
				if (first)
					words_left <= has_opnd ? 2'd3 : 2'd0;
				else
					words_left <= words_left - 2'd1;
			end else if (in_ack && !in_req) begin
				// source dropped req so the cycle closes
				in_ack <= 1'b0;
			end
		end
	end

	// command payload
	always_ff @(posedge clk_sys) begin
		if (take) begin
			if (first) begin
				cmd.op <= in_word.ctrl.op;
				// counts above the limit act as the limit
				if (in_word.ctrl.count > 6'(`FPA_MAX_SHIFT))
					cmd.count <= 6'(`FPA_MAX_SHIFT);
				else
					cmd.count <= in_word.ctrl.count;
			end else begin
				case (words_left)
					2'd3: cmd.operand[0:15] <= in_word.data;
					2'd2: cmd.operand[16:31] <= in_word.data;
					// only the upper byte of word3 is used
					default: cmd.operand[32:39] <= in_word.data[15:8];
				endcase
			end
		end
	end

	// source keeps req up until it sees ack
	a_ack_after_req: assert property (@(posedge clk_sys) disable iff (_0_t)
		$rose(in_ack) |-> in_req);

endmodule

//--- fpa_cmd_fifo.sv
// circular command FIFO, read data shows the oldest entry
// writer must not push when full, reader must not pop when empty
`include "fpa_params.svh"

module fpa_cmd_fifo #(
	parameter int DEPTH = `FPA_FIFO_DEPTH
) (
	input  logic                  clk_sys,
	input  logic                  _0_t,
	input  logic                  push,
	input  fpa_bus_pkg::fpa_cmd_t cmd,
	output logic                  full,
	input  logic                  pop,
	output logic                  cmd_valid,
	output fpa_bus_pkg::fpa_cmd_t cmd_out
);

	localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
	localparam int CNT_W = $clog2(DEPTH + 1);

	fpa_bus_pkg::fpa_cmd_t mem [DEPTH];
	logic [PTR_W-1:0] wr_ptr;
	logic [PTR_W-1:0] rd_ptr;
	logic [CNT_W-1:0] count;
	logic do_wr;
	logic do_rd;

	assign full = (count == CNT_W'(DEPTH));
	assign cmd_valid = (count != '0);
	assign cmd_out = mem[rd_ptr];

	assign do_wr = push && !full;
	assign do_rd = pop && cmd_valid;

	// pointers wrap at DEPTH, any depth works
	always_ff @(posedge clk_sys or posedge _0_t) begin
		if (_0_t) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count <= '0;
		end else begin
			if (do_wr)
				wr_ptr <= (wr_ptr == PTR_W'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
			if (do_rd)
				rd_ptr <= (rd_ptr == PTR_W'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
			// both at once leaves count alone
			if (do_wr && !do_rd)
				count <= count + 1'b1;
			else if (do_rd && !do_wr)
				count <= count - 1'b1;
		end
	end

	always_ff @(posedge clk_sys) begin
		if (do_wr)
			mem[wr_ptr] <= cmd;
	end

	// assembler back-pressure keeps pushes out of a full FIFO
	a_no_overflow: assert property (@(posedge clk_sys) disable iff (_0_t)
		push |-> !full);

	// unit pops only what it sees as valid
	a_no_underflow: assert property (@(posedge clk_sys) disable iff (_0_t)
		pop |-> cmd_valid);

endmodule

//--- fpalu.sv
// 40-bit mantissa adder, three segments with rippled carries
// subtract is T plus complement of C plus one
module fpalu (
	input  fpa_data_pkg::fpa_mant_t  t,
	input  fpa_data_pkg::fpa_mant_t  c,
	input  logic                     sub,
	output fpa_data_pkg::fpa_mant_t  sum,
	output fpa_data_pkg::fpa_carry_t carry,
	output logic                     ovf
);

	fpa_data_pkg::fpa_mant_t b;

	// segment results with their carry in the top bit
	logic [8:0]  seg_lo;
	logic [16:0] seg_mid;
	logic [16:0] seg_hi;

	// second operand, inverted on subtract
	assign b = sub ? ~c : c;

	// bits 32..39 take the +1 of a subtract
	assign seg_lo = {1'b0, t[32:39]} + {1'b0, b[32:39]} + {8'd0, sub};

	// bits 16..31
	assign seg_mid = {1'b0, t[16:31]} + {1'b0, b[16:31]} + {16'd0, seg_lo[8]};

	// bits 0..15
	assign seg_hi = {1'b0, t[0:15]} + {1'b0, b[0:15]} + {16'd0, seg_mid[16]};

	assign sum = {seg_hi[15:0], seg_mid[15:0], seg_lo[7:0]};

	assign carry.fp0 = seg_hi[16];
	assign carry.fp16 = seg_mid[16];
	assign carry.p32 = seg_lo[8];

	// same input signs, result sign differs
	assign ovf = (t[0] == b[0]) && (sum[0] != t[0]);

endmodule

//--- fpa.sv
// mantissa unit with T, M and C registers, one command at a time
// results leave as four words on a four-phase req/ack link
`include "fpa_params.svh"

module fpa (
	input  logic                    clk_sys,
	input  logic                    _0_t,
	input  logic                    cmd_valid,
	input  fpa_bus_pkg::fpa_cmd_t   cmd_in,
	output logic                    pop,
	output logic                    out_req,
	output logic [`FPA_WORD_W-1:0]  out_word,
	input  logic                    out_ack
);

	typedef enum logic [2:0] {
		S_IDLE,
		S_EXEC,
		S_SHIFT,
		S_RD_REQ,
		S_RD_WAIT
	} state_e;

	state_e state;
	fpa_bus_pkg::fpa_op_e op_r;
	logic [5:0] shift_cnt;
	logic [1:0] rd_idx;

	// accumulator, extension and operand
	fpa_data_pkg::fpa_mant_t t;
	fpa_data_pkg::fpa_mant_t m;
	fpa_data_pkg::fpa_mant_t c;

	// flags kept from the last add or subtract
	logic flag_v;
	logic flag_c;

	fpa_data_pkg::fpa_mant_t  alu_sum;
	fpa_data_pkg::fpa_carry_t alu_carry;
	logic alu_ovf;
	fpa_data_pkg::fpa_flags_t flags_rd;

	fpalu u_fpalu (
		.t(t),
		.c(c),
		.sub(op_r == fpa_bus_pkg::OP_SUB),
		.sum(alu_sum),
		.carry(alu_carry),
		.ovf(alu_ovf)
	);

	// z and m come from T as it is now
	assign flags_rd.z = (t == '0);
	assign flags_rd.m = t[0];
	assign flags_rd.v = flag_v;
	assign flags_rd.c = flag_c;

	// readout mux, word 2 holds the low T byte and the high M byte
	always_comb begin
		case (rd_idx)
			2'd0: out_word = t[0:15];
			2'd1: out_word = t[16:31];
			2'd2: out_word = {t[32:39], m[0:7]};
			default: out_word = {flags_rd, 12'd0};
		endcase
	end

	always_ff @(posedge clk_sys or posedge _0_t) begin
		if (_0_t) begin
			state <= S_IDLE;
			op_r <= fpa_bus_pkg::OP_LOAD;
			shift_cnt <= '0;
			rd_idx <= '0;
			pop <= 1'b0;
			out_req <= 1'b0;
			t <= '0;
			m <= '0;
			c <= '0;
			flag_v <= 1'b0;
			flag_c <= 1'b0;
		end else begin
			pop <= 1'b0;
			case (state)
				S_IDLE: begin
					// wait out the pop cycle so one entry is not taken twice
					if (cmd_valid && !pop) begin
						pop <= 1'b1;
						op_r <= cmd_in.op;
						shift_cnt <= cmd_in.count;
						case (cmd_in.op)
							fpa_bus_pkg::OP_LOAD,
							fpa_bus_pkg::OP_ADD,
							fpa_bus_pkg::OP_SUB: begin
								c <= cmd_in.operand;
								state <= S_EXEC;
							end
							fpa_bus_pkg::OP_SHR,
							fpa_bus_pkg::OP_SHL: begin
								// a zero count ends here
								if (cmd_in.count != 6'd0)
									state <= S_SHIFT;
							end
							fpa_bus_pkg::OP_READ: begin
								rd_idx <= 2'd0;
								out_req <= 1'b1;
								state <= S_RD_REQ;
							end
							// codes 6 and 7 only pop
							default: state <= S_IDLE;
						endcase
					end
				end
				S_EXEC: begin
					if (op_r == fpa_bus_pkg::OP_LOAD) begin
						t <= c;
						m <= '0;
					end else begin
						t <= alu_sum;
						flag_v <= alu_ovf;
						flag_c <= alu_carry.fp0;
					end
					state <= S_IDLE;
				end
				S_SHIFT: begin
					// one bit of T:M per cycle
					if (op_r == fpa_bus_pkg::OP_SHR) begin
						t <= {t[0], t[0:38]};
						m <= {t[39], m[0:38]};
					end else begin
						t <= {t[1:39], m[0]};
						m <= {m[1:39], 1'b0};
					end
					shift_cnt <= shift_cnt - 6'd1;
					if (shift_cnt == 6'd1)
						state <= S_IDLE;
				end
				S_RD_REQ: begin
					// drop req once the sink has the word
					if (out_ack) begin
						out_req <= 1'b0;
						state <= S_RD_WAIT;
					end
				end
				S_RD_WAIT: begin
					if (!out_ack) begin
						if (rd_idx == 2'd3) begin
							state <= S_IDLE;
						end else begin
							rd_idx <= rd_idx + 2'd1;
							out_req <= 1'b1;
							state <= S_RD_REQ;
						end
					end
				end
				default: state <= S_IDLE;
			endcase
		end
	end

	// word held until the sink acks
	a_out_stable: assert property (@(posedge clk_sys) disable iff (_0_t)
		(out_req && !out_ack) |=> $stable(out_word));

endmodule

//--- fpa_top.sv
// word-bus mantissa unit, input link to assembler, FIFO, then unit
// both links are four-phase req/ack on clk_sys
`include "fpa_params.svh"

module fpa_top (
	input  logic                   clk_sys,
	input  logic                   _0_t,
	input  logic                   in_req,
	input  fpa_bus_pkg::fpa_word_u in_word,
	output logic                   in_ack,
	output logic                   out_req,
	output logic [`FPA_WORD_W-1:0] out_word,
	input  logic                   out_ack
);

	logic push;
	logic full;
	logic pop;
	logic cmd_valid;
	fpa_bus_pkg::fpa_cmd_t cmd;
	fpa_bus_pkg::fpa_cmd_t cmd_out;

	fpa_word_assembler u_asm (
		.clk_sys(clk_sys),
		._0_t(_0_t),
		.in_req(in_req),
		.in_word(in_word),
		.in_ack(in_ack),
		.full(full),
		.push(push),
		.cmd(cmd)
	);

	fpa_cmd_fifo #(
		.DEPTH(`FPA_FIFO_DEPTH)
	) u_fifo (
		.clk_sys(clk_sys),
		._0_t(_0_t),
		.push(push),
		.cmd(cmd),
		.full(full),
		.pop(pop),
		.cmd_valid(cmd_valid),
		.cmd_out(cmd_out)
	);

	fpa u_fpa (
		.clk_sys(clk_sys),
		._0_t(_0_t),
		.cmd_valid(cmd_valid),
		.cmd_in(cmd_out),
		.pop(pop),
		.out_req(out_req),
		.out_word(out_word),
		.out_ack(out_ack)
	);

endmodule

//--- tb_fpa.sv
// trace-driven testbench for fpa_top, fpa_trace.txt is read from the project root
// result words are acked after a random 0 to 3 cycle delay, stops at the first mismatch
`include "fpa_params.svh"

module tb_fpa;
	timeunit 1ns;
	timeprecision 100ps;

	logic clk_sys;
	logic _0_t;
	logic in_req;
	fpa_bus_pkg::fpa_word_u in_word;
	logic in_ack;
	logic out_req;
	logic [`FPA_WORD_W-1:0] out_word;
	logic out_ack;

	// words and pauses for the driver, in trace order
	byte drv_kind_q[$];
	int drv_val_q[$];
	// expected result words, oldest first
	logic [`FPA_WORD_W-1:0] exp_q[$];

	int n_records;
	int exp_total;
	int matched;
	int cycles = 0;
	int cycle_limit;
	integer seed = 32'hc0c;
	logic extra_word;

	fpa_top u_fpa_top (
		.clk_sys(clk_sys),
		._0_t(_0_t),
		.in_req(in_req),
		.in_word(in_word),
		.in_ack(in_ack),
		.out_req(out_req),
		.out_word(out_word),
		.out_ack(out_ack)
	);

	// 8 ns period
	initial clk_sys = 1'b0;
	always #4 clk_sys = ~clk_sys;

	// run length guard, limit set once the trace is known
	always @(posedge clk_sys) begin
		cycles <= cycles + 1;
		if (cycle_limit != 0 && cycles >= cycle_limit) begin
			$display("timeout after %0d cycles, %0d of %0d result words received",
				cycles, matched, exp_total);
			$display("Verification failed");
			$fatal(1, "run stopped by timeout");
		end
	end

	task automatic compare_word(input string name, input logic [`FPA_WORD_W-1:0] expected,
			input logic [`FPA_WORD_W-1:0] got);
		if (got !== expected) begin
			$display("** Error at %0t ns: %s expected %h, got %h", $time, name, expected, got);
			$display("Verification failed");
			$fatal(1, "result mismatch");
		end
	endtask

	// W and P records go to the driver, R records to the expected queue
	task automatic read_trace();
		int fd;
		int code;
		string line;
		byte kind;
		int value;
		fd = $fopen("fpa_trace.txt", "r");
		if (fd == 0) begin
			$display("cannot open fpa_trace.txt for reading");
			$display("Verification failed");
			$fatal(1, "missing trace file");
		end else begin
			while (!$feof(fd)) begin
				line = "";
				code = $fgets(line, fd);
				// skip blank and comment lines
				if (code > 0 && line.len() > 2 && line.getc(0) != "#") begin
					kind = line.getc(0);
					if (kind == "P")
						code = $sscanf(line, "%c %d", kind, value);
					else
						code = $sscanf(line, "%c %h", kind, value);
					if (code != 2 || (kind != "W" && kind != "R" && kind != "P")) begin
						$display("trace line not understood: %s", line);
						$display("Verification failed");
						$fatal(1, "bad trace line");
					end else begin
						n_records++;
						if (kind == "R") begin
							exp_q.push_back(value[15:0]);
						end else begin
							drv_kind_q.push_back(kind);
							drv_val_q.push_back(value);
						end
					end
				end
			end
			$fclose(fd);
		end
	endtask

	// one four-phase cycle on the input link
	task automatic send_word(input logic [`FPA_WORD_W-1:0] w);
		@(posedge clk_sys);
		in_word.data <= w;
		in_req <= 1'b1;
		// ack is held back while the FIFO is full
		do @(negedge clk_sys); while (!in_ack);
		@(posedge clk_sys);
		in_req <= 1'b0;
		do @(negedge clk_sys); while (in_ack);
	endtask

	task automatic drive_trace();
		for (int i = 0; i < drv_kind_q.size(); i++) begin
			if (drv_kind_q[i] == "P")
				repeat (drv_val_q[i]) @(posedge clk_sys);
			else
				send_word(drv_val_q[i][15:0]);
		end
	endtask

	// output link sink, one expected word per handshake
	task automatic collect_results();
		logic [`FPA_WORD_W-1:0] got;
		logic [`FPA_WORD_W-1:0] expected;
		int delay;
		while (matched < exp_total) begin
			// word is valid once out_req is up
			do @(negedge clk_sys); while (!out_req);
			got = out_word;
			expected = exp_q.pop_front();
			compare_word("out_word", expected, got);
			delay = $unsigned($random(seed)) % 4;
			repeat (delay) @(posedge clk_sys);
			@(posedge clk_sys);
			out_ack <= 1'b1;
			// unit drops req, then ack goes low
			do @(negedge clk_sys); while (out_req);
			@(posedge clk_sys);
			out_ack <= 1'b0;
			matched++;
		end
	endtask

	initial begin
		_0_t = 1'b1;
		in_req = 1'b0;
		in_word = '0;
		out_ack = 1'b0;
		n_records = 0;
		matched = 0;
		cycle_limit = 0;
		extra_word = 1'b0;
		read_trace();
		exp_total = exp_q.size();
		cycle_limit = 200 + 60 * n_records;
		repeat (16) @(posedge clk_sys);
		_0_t <= 1'b0;
		fork
			drive_trace();
			collect_results();
		join
		// quiet window, no word beyond the trace may appear
		repeat (40) begin
			@(negedge clk_sys);
			if (out_req)
				extra_word = 1'b1;
		end
		if (!extra_word) begin
			$display("Verification passed");
			$finish;
		end else begin
			$display("unit sent a result word after the last expected one");
			$display("Verification failed");
			$fatal(1, "extra result word");
		end
	end

endmodule

//--- fpa_trace.txt
# W hhhh: word sent on the input link, R hhhh: expected word on the output link
# P n: n idle cycles before the next word, lines starting with # are comments
# LOAD 8123456789, low byte of the third word is ignored
W 0000
W 8123
W 4567
W 89C3
W A000
R 8123
R 4567
R 8900
R 4000
# SHR by 0, 1 and 17 on T:M
W 6000
W 6080
W 6880
W A000
R FFFF
R E048
R D159
R 4000
# SHL by 17, 1 and 0 undoes it
W 8880
W 8080
W 8000
W A000
R 8123
R 4567
R 8900
R 4000
# LOAD 123456789A then SHR 40 moves T into M
W 0000
W 1234
W 5678
W 9A5A
W 7400
W A000
R 0000
R 0000
R 0012
R 8000
# SHL 40 brings it back
W 9400
W A000
R 1234
R 5678
R 9A00
R 0000
# SHR with count 63 acts as 40, then opcode 6
W 7F80
W C000
W A000
R 0000
R 0000
R 0012
R 8000
P 6
# 7FFFFFFFFF + 1 overflows without carry
W 0000
W 7FFF
W FFFF
W FF00
W 2000
W 0000
W 0000
W 0100
W A000
R 8000
R 0000
R 0000
R 6000
# 5 - 7 borrows
W 0000
W 0000
W 0000
W 0500
W 4000
W 0000
W 0000
W 0700
W A000
R FFFF
R FFFF
R FE00
R 4000
# -2 + 2 gives zero with carry
W 2000
W 0000
W 0000
W 0200
W A000
R 0000
R 0000
R 0000
R 9000
# burst behind a READ, long shifts fill the FIFO
W A000
W 0000
W 4000
W 0000
W 0000
W 7400
W 9400
W 6080
W A000
W 8080
W 8080
W A000
R 0000
R 0000
R 0000
R 9000
R 2000
R 0000
R 0000
R 1000
R 8000
R 0000
R 0000
R 5000

//--- sources.f
+incdir+.
fpa_bus_pkg.sv
fpa_data_pkg.sv
fpa_word_assembler.sv
fpa_cmd_fifo.sv
fpalu.sv
fpa.sv
fpa_top.sv
tb_fpa.sv

//--- run_sim.sh
#!/usr/bin/env bash
# build the testbench with Verilator and run it from the project root
set -e

cd "$(dirname "$0")"

verilator --binary --assert \
	--top-module tb_fpa \
	-f sources.f \
	--Mdir obj_dir \
	-o tb_fpa_sim

# exit status of the simulation is the result
./obj_dir/tb_fpa_sim
